// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_imm      = 7'b0010011;
  localparam logic [6:0] op_reg      = 7'b0110011;
  localparam logic [6:0] op_system   = 7'b1110011;
  localparam logic [6:0] op_misc_mem = 7'b0001111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } br_op_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_pc_plus4,
    wb_csr
  } wb_sel_t;

  // redirect target source in execute
  typedef enum logic [1:0] {
    pc_rel,
    pc_rs1,
    pc_mtvec,
    pc_mepc
  } pc_sel_t;

  typedef enum logic [2:0] {
    csr_none,
    csr_write,
    csr_set,
    csr_clear,
    csr_ecall,
    csr_mret
  } csr_op_t;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam logic [31:0] cause_ecall_m = 32'd11;

endpackage

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic [31:0] inst_pc,
  input  logic        inst_valid,
  input  logic        stall,
  input  logic        flush,
  input  logic [4:0]  e_rd,
  input  logic        e_rd_wen,
  output logic        inst_ready,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  output logic        d_valid,
  output logic [31:0] d_pc,
  output logic [31:0] imm,
  output alu_op_t     alu_op,
  output logic        use_imm,
  output logic        use_pc,
  output br_op_t      br_op,
  output logic        is_jal,
  output logic        is_jalr,
  output wb_sel_t     wb_sel,
  output logic [4:0]  rd,
  output logic        rd_wen,
  output logic [11:0] csr_addr,
  output csr_op_t     csr_op,
  output logic        fence_i
);

  localparam logic [31:0] inst_ecall = 32'h0000_0073;
  localparam logic [31:0] inst_mret  = 32'h3020_0073;

  logic [31:0] inst_q;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] u_imm;
  logic [31:0] j_imm;
  logic [31:0] b_imm;
  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic        writes_rd;
  logic [4:0]  src1;
  logic [4:0]  src2;
  logic        d_busy;
  logic        hit1;
  logic        hit2;

  // funct3 to ALU op, alt selects sub/sra
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_decode = alt ? alu_sub : alu_add;
      3'b001:  alu_decode = alu_sll;
      3'b010:  alu_decode = alu_slt;
      3'b011:  alu_decode = alu_sltu;
      3'b100:  alu_decode = alu_xor;
      3'b101:  alu_decode = alt ? alu_sra : alu_srl;
      3'b110:  alu_decode = alu_or;
      default: alu_decode = alu_and;
    endcase
  endfunction

  function automatic br_op_t br_decode(input logic [2:0] f3);
    case (f3)
      3'b000:  br_decode = br_eq;
      3'b001:  br_decode = br_ne;
      3'b100:  br_decode = br_lt;
      3'b101:  br_decode = br_ge;
      3'b110:  br_decode = br_ltu;
      3'b111:  br_decode = br_geu;
      default: br_decode = br_none;
    endcase
  endfunction

  // hold off a reader of an in-flight destination, and the slot behind a redirect
  assign src1 = inst[19:15];
  assign src2 = inst[24:20];
  assign d_busy = d_valid && rd_wen;
  assign hit1 = (src1 != 5'd0) && ((d_busy && src1 == rd) || (e_rd_wen && src1 == e_rd));
  assign hit2 = (src2 != 5'd0) && ((d_busy && src2 == rd) || (e_rd_wen && src2 == e_rd));
  assign inst_ready = !flush && !hit1 && !hit2;

  always_ff @(posedge clock) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else if (!stall) begin
      d_valid <= inst_valid && inst_ready;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall && inst_valid && inst_ready) begin
      inst_q <= inst;
      d_pc <= inst_pc;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign u_imm = {inst_q[31:12], 12'd0};
  assign j_imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
  assign b_imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};
  assign s_imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};

  // LUI reads x0 so execute sees a clean zero on rs1
  assign rs1_addr = (opcode == op_lui) ? 5'd0 : inst_q[19:15];
  assign rs2_addr = inst_q[24:20];
  assign rd = inst_q[11:7];
  assign rd_wen = writes_rd && (rd != 5'd0);
  assign csr_addr = inst_q[31:20];

  always_comb begin
    imm = 32'd0;
    alu_op = alu_add;
    use_imm = 1'b0;
    use_pc = 1'b0;
    br_op = br_none;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    wb_sel = wb_alu;
    writes_rd = 1'b0;
    csr_op = csr_none;
    fence_i = 1'b0;
    case (opcode)
      op_lui: begin
        imm = u_imm;
        alu_op = alu_pass_b;
        use_imm = 1'b1;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        imm = u_imm;
        use_imm = 1'b1;
        use_pc = 1'b1;
        writes_rd = 1'b1;
      end
      op_jal: begin
        imm = j_imm;
        is_jal = 1'b1;
        wb_sel = wb_pc_plus4;
        writes_rd = 1'b1;
      end
      op_jalr: begin
        imm = i_imm;
        is_jalr = 1'b1;
        wb_sel = wb_pc_plus4;
        writes_rd = 1'b1;
      end
      op_branch: begin
        imm = b_imm;
        br_op = br_decode(funct3);
      end
      // memory ops retire without effect
      op_load:  imm = i_imm;
      op_store: imm = s_imm;
      op_imm: begin
        imm = i_imm;
        use_imm = 1'b1;
        alu_op = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
        writes_rd = 1'b1;
      end
      op_reg: begin
        alu_op = alu_decode(funct3, funct7[5]);
        writes_rd = 1'b1;
      end
      op_system: begin
        if (inst_q == inst_ecall) begin
          csr_op = csr_ecall;
        end else if (inst_q == inst_mret) begin
          csr_op = csr_mret;
        end else if (funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b011) begin
          csr_op = (funct3 == 3'b001) ? csr_write : (funct3 == 3'b010) ? csr_set : csr_clear;
          wb_sel = wb_csr;
          writes_rd = 1'b1;
        end
      end
      op_misc_mem: fence_i = (funct3 == 3'b001);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic        wb_wen,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wb_wen && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        d_valid,
  input  logic [31:0] d_pc,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [31:0] imm,
  input  alu_op_t     alu_op,
  input  logic        use_imm,
  input  logic        use_pc,
  input  br_op_t      br_op,
  input  logic        is_jal,
  input  logic        is_jalr,
  input  wb_sel_t     wb_sel,
  input  logic [4:0]  rd,
  input  logic        rd_wen,
  input  logic [11:0] d_csr_addr,
  input  csr_op_t     d_csr_op,
  input  logic        fence_i,
  input  logic [31:0] csr_rdata,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic        flush,
  output logic [4:0]  e_rd,
  output logic        e_rd_wen,
  output logic [11:0] csr_addr,
  output csr_op_t     csr_op,
  output logic [31:0] csr_wdata,
  output logic [31:0] trap_pc,
  output logic        wb_wen,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic        clear_cache
);

  logic        e_valid;
  logic [31:0] pc_q;
  logic [31:0] rs1_q;
  logic [31:0] rs2_q;
  logic [31:0] imm_q;
  alu_op_t     alu_op_q;
  logic        use_imm_q;
  logic        use_pc_q;
  br_op_t      br_op_q;
  logic        is_jal_q;
  logic        is_jalr_q;
  wb_sel_t     wb_sel_q;
  logic [4:0]  rd_q;
  logic        rd_wen_q;
  logic [11:0] csr_addr_q;
  csr_op_t     csr_op_q;
  logic        fence_q;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic        br_true;
  pc_sel_t     pc_sel;
  logic [31:0] target;
  logic [31:0] result;

  always_ff @(posedge clock) begin
    if (reset) begin
      e_valid <= 1'b0;
    end else if (!stall) begin
      // the slot behind a redirect is dropped
      e_valid <= d_valid && !flush;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      pc_q <= d_pc;
      rs1_q <= rs1_data;
      rs2_q <= rs2_data;
      imm_q <= imm;
      alu_op_q <= alu_op;
      use_imm_q <= use_imm;
      use_pc_q <= use_pc;
      br_op_q <= br_op;
      is_jal_q <= is_jal;
      is_jalr_q <= is_jalr;
      wb_sel_q <= wb_sel;
      rd_q <= rd;
      rd_wen_q <= rd_wen;
      csr_addr_q <= d_csr_addr;
      csr_op_q <= d_csr_op;
      fence_q <= fence_i;
    end
  end

  assign op_a = use_pc_q ? pc_q : rs1_q;
  assign op_b = use_imm_q ? imm_q : rs2_q;

  always_comb begin
    case (alu_op_q)
      alu_sub:    alu_out = op_a - op_b;
      alu_sll:    alu_out = op_a << op_b[4:0];
      alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_out = {31'd0, op_a < op_b};
      alu_xor:    alu_out = op_a ^ op_b;
      alu_srl:    alu_out = op_a >> op_b[4:0];
      alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_out = op_a | op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_pass_b: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (br_op_q)
      br_eq:   br_true = (rs1_q == rs2_q);
      br_ne:   br_true = (rs1_q != rs2_q);
      br_lt:   br_true = $signed(rs1_q) < $signed(rs2_q);
      br_ge:   br_true = $signed(rs1_q) >= $signed(rs2_q);
      br_ltu:  br_true = (rs1_q < rs2_q);
      br_geu:  br_true = (rs1_q >= rs2_q);
      default: br_true = 1'b0;
    endcase
  end

  // csr_op is already qualified by the stage valid
  assign csr_op = e_valid ? csr_op_q : csr_none;
  assign csr_addr = csr_addr_q;
  assign csr_wdata = rs1_q;
  assign trap_pc = pc_q;

  assign pc_sel = (csr_op == csr_ecall) ? pc_mtvec :
                  (csr_op == csr_mret) ? pc_mepc :
                  is_jalr_q ? pc_rs1 : pc_rel;

  always_comb begin
    case (pc_sel)
      pc_rs1:   target = (rs1_q + imm_q) & ~32'd1;
      pc_mtvec: target = mtvec;
      pc_mepc:  target = mepc;
      default:  target = pc_q + imm_q;
    endcase
  end

  assign flush = e_valid && (is_jal_q || is_jalr_q || br_true ||
                             csr_op == csr_ecall || csr_op == csr_mret);
  assign e_rd = rd_q;
  assign e_rd_wen = e_valid && rd_wen_q;

  always_comb begin
    case (wb_sel_q)
      wb_pc_plus4: result = pc_q + 32'd4;
      wb_csr:      result = csr_rdata;
      default:     result = alu_out;
    endcase
  end

  // one-cycle pulses, none on a stalled edge
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_wen <= 1'b0;
      redirect_valid <= 1'b0;
      clear_cache <= 1'b0;
    end else begin
      wb_wen <= !stall && e_rd_wen;
      redirect_valid <= !stall && flush;
      clear_cache <= !stall && e_valid && fence_q;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      wb_rd <= rd_q;
      wb_data <= result;
      redirect_pc <= target;
    end
  end

endmodule

`default_nettype wire

// File: rv_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_csr_file import rv_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic [11:0] csr_addr,
  input  csr_op_t     csr_op,
  input  logic [31:0] csr_wdata,
  input  logic [31:0] trap_pc,
  output logic [31:0] csr_rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  logic [31:0] mstatus;
  logic [31:0] mcause;
  logic [31:0] new_value;
  logic        access;

  always_comb begin
    case (csr_addr)
      csr_mstatus: csr_rdata = mstatus;
      csr_mtvec:   csr_rdata = mtvec;
      csr_mepc:    csr_rdata = mepc;
      csr_mcause:  csr_rdata = mcause;
      default:     csr_rdata = 32'd0;
    endcase
  end

  // read-modify-write on the old value
  always_comb begin
    case (csr_op)
      csr_write: new_value = csr_wdata;
      csr_set:   new_value = csr_rdata | csr_wdata;
      csr_clear: new_value = csr_rdata & ~csr_wdata;
      default:   new_value = csr_rdata;
    endcase
  end

  assign access = (csr_op == csr_write) || (csr_op == csr_set) || (csr_op == csr_clear);

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= 32'd0;
      mtvec <= mtvec_reset;
      mepc <= 32'd0;
      mcause <= 32'd0;
    end else if (!stall) begin
      if (access) begin
        case (csr_addr)
          csr_mstatus: mstatus <= new_value;
          csr_mtvec:   mtvec <= new_value;
          csr_mepc:    mepc <= new_value;
          csr_mcause:  mcause <= new_value;
          default: ;
        endcase
      end else if (csr_op == csr_ecall) begin
        mepc <= trap_pc;
        mcause <= cause_ecall_m;
      end
    end
  end

endmodule

`default_nettype wire

// File: rv_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core import rv_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst,
  input  logic [31:0] inst_pc,
  input  logic        inst_valid,
  input  logic        stall,
  output logic        inst_ready,
  output logic        wb_valid,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic        clear_cache
);

  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        d_valid;
  logic [31:0] d_pc;
  logic [31:0] imm;
  alu_op_t     alu_op;
  logic        use_imm;
  logic        use_pc;
  br_op_t      br_op;
  logic        is_jal;
  logic        is_jalr;
  wb_sel_t     wb_sel;
  logic [4:0]  rd;
  logic        rd_wen;
  logic [11:0] d_csr_addr;
  csr_op_t     d_csr_op;
  logic        fence_i;
  logic        flush;
  logic [4:0]  e_rd;
  logic        e_rd_wen;
  logic [11:0] csr_addr;
  csr_op_t     csr_op;
  logic [31:0] csr_wdata;
  logic [31:0] trap_pc;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;

  rv_decoder i_rv_decoder (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid),
    .stall      (stall),
    .flush      (flush),
    .e_rd       (e_rd),
    .e_rd_wen   (e_rd_wen),
    .inst_ready (inst_ready),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .d_valid    (d_valid),
    .d_pc       (d_pc),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .br_op      (br_op),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .wb_sel     (wb_sel),
    .rd         (rd),
    .rd_wen     (rd_wen),
    .csr_addr   (d_csr_addr),
    .csr_op     (d_csr_op),
    .fence_i    (fence_i)
  );

  rv_regfile i_rv_regfile (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb_wen   (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_rv_execute (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .d_valid        (d_valid),
    .d_pc           (d_pc),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .imm            (imm),
    .alu_op         (alu_op),
    .use_imm        (use_imm),
    .use_pc         (use_pc),
    .br_op          (br_op),
    .is_jal         (is_jal),
    .is_jalr        (is_jalr),
    .wb_sel         (wb_sel),
    .rd             (rd),
    .rd_wen         (rd_wen),
    .d_csr_addr     (d_csr_addr),
    .d_csr_op       (d_csr_op),
    .fence_i        (fence_i),
    .csr_rdata      (csr_rdata),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .flush          (flush),
    .e_rd           (e_rd),
    .e_rd_wen       (e_rd_wen),
    .csr_addr       (csr_addr),
    .csr_op         (csr_op),
    .csr_wdata      (csr_wdata),
    .trap_pc        (trap_pc),
    .wb_wen         (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .clear_cache    (clear_cache)
  );

  rv_csr_file #(
    .mtvec_reset (mtvec_reset)
  ) i_rv_csr_file (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .csr_wdata (csr_wdata),
    .trap_pc   (trap_pc),
    .csr_rdata (csr_rdata),
    .mtvec     (mtvec),
    .mepc      (mepc)
  );

endmodule

`default_nettype wire

// File: tb_rv_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_core import rv_pkg::*;;

  logic        clock;
  logic        reset;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_valid;
  logic        stall;
  logic        inst_ready;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        clear_cache;

  int          errors;
  int          edge_count;
  logic [31:0] lfsr;
  logic [31:0] pc_now;
  int          last_acc;
  logic [31:0] last_pc;
  int          last_waits;

  // reference state
  logic [31:0] model_x [0:31];
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;

  // pulses observed on the falling edge
  int          wbq_rd[$];
  logic [31:0] wbq_data[$];
  int          wbq_edge[$];
  logic [31:0] rdq_pc[$];
  int          rdq_edge[$];
  int          ccq_edge[$];

  rv_exec_core #(
    .mtvec_reset (32'h0000_0100)
  ) i_rv_exec_core (
    .clock          (clock),
    .reset          (reset),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .inst_valid     (inst_valid),
    .stall          (stall),
    .inst_ready     (inst_ready),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .clear_cache    (clear_cache)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) edge_count = edge_count + 1;

  always @(negedge clock) begin
    if (wb_valid) begin
      wbq_rd.push_back(int'(wb_rd));
      wbq_data.push_back(wb_data);
      wbq_edge.push_back(edge_count);
    end
    if (redirect_valid) begin
      rdq_pc.push_back(redirect_pc);
      rdq_edge.push_back(edge_count);
    end
    if (clear_cache) begin
      ccq_edge.push_back(edge_count);
    end
  end

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm12, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // starts on a falling edge and returns on the falling edge after acceptance
  task automatic send_inst(input logic [31:0] word);
    int waits;
    waits = 0;
    inst = word;
    inst_pc = pc_now;
    inst_valid = 1'b1;
    #1;
    while (!(inst_ready && !stall) && waits < 50) begin
      @(negedge clock);
      waits++;
      #1;
    end
    if (waits >= 50) begin
      $display("timeout waiting for inst_ready on %h", word);
      errors++;
    end
    last_acc = edge_count + 1;
    last_pc = pc_now;
    last_waits = waits;
    @(posedge clock);
    @(negedge clock);
    inst_valid = 1'b0;
    pc_now = pc_now + 32'd4;
  endtask

  task automatic expect_wb(input int rd, input logic [31:0] data, input int at_edge);
    int waited;
    waited = 0;
    while (wbq_rd.size() == 0 && waited < 50) begin
      @(posedge clock);
      waited++;
    end
    if (wbq_rd.size() == 0) begin
      $display("timeout waiting for writeback of x%0d", rd);
      errors++;
    end else begin
      if (wbq_rd[0] != rd) begin
        $display("Mismatch wb_rd: got %h expected %h", wbq_rd[0], rd);
        errors++;
      end
      if (wbq_data[0] != data) begin
        $display("Mismatch wb_data: got %h expected %h", wbq_data[0], data);
        errors++;
      end
      if (wbq_edge[0] != at_edge) begin
        $display("writeback of x%0d came at edge %0d instead of %0d", rd, wbq_edge[0], at_edge);
        errors++;
      end
      void'(wbq_rd.pop_front());
      void'(wbq_data.pop_front());
      void'(wbq_edge.pop_front());
    end
    @(negedge clock);
  endtask

  task automatic expect_redirect(input logic [31:0] target, input int at_edge);
    int waited;
    waited = 0;
    while (rdq_pc.size() == 0 && waited < 50) begin
      @(posedge clock);
      waited++;
    end
    if (rdq_pc.size() == 0) begin
      $display("timeout waiting for a redirect to %h", target);
      errors++;
    end else begin
      if (rdq_pc[0] != target) begin
        $display("Mismatch redirect_pc: got %h expected %h", rdq_pc[0], target);
        errors++;
      end
      if (rdq_edge[0] != at_edge) begin
        $display("redirect came at edge %0d instead of %0d", rdq_edge[0], at_edge);
        errors++;
      end
      void'(rdq_pc.pop_front());
      void'(rdq_edge.pop_front());
    end
    @(negedge clock);
  endtask

  // let the pipeline drain and expect nothing left over
  task automatic expect_quiet(input string what);
    repeat (5) @(posedge clock);
    if (wbq_rd.size() != 0 || rdq_pc.size() != 0) begin
      $display("unexpected writeback or redirect after %s", what);
      errors++;
      wbq_rd.delete();
      wbq_data.delete();
      wbq_edge.delete();
      rdq_pc.delete();
      rdq_edge.delete();
    end
    @(negedge clock);
  endtask

  task automatic run_write(input logic [31:0] word, input int rd, input logic [31:0] value);
    send_inst(word);
    if (rd != 0) begin
      expect_wb(rd, value, last_acc + 2);
      model_x[rd] = value;
    end
  endtask

  task automatic test_arith();
    logic [31:0] v;
    logic [11:0] im;
    for (int r = 1; r <= 6; r++) begin
      v = lfsr_bits(32);
      run_write({v[31:12], 5'(r), op_lui}, r, {v[31:12], 12'd0});
      run_write(enc_i(v[11:0], 5'(r), 3'd0, 5'(r), op_imm), r,
                model_x[r] + sext12(v[11:0]));
    end
    for (int f = 0; f < 8; f++) begin
      run_write(enc_r(7'd0, 5'd2, 5'd1, 3'(f), 5'd10), 10,
                alu_ref(3'(f), 1'b0, model_x[1], model_x[2]));
    end
    run_write(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd10), 10,
              alu_ref(3'd0, 1'b1, model_x[3], model_x[4]));
    run_write(enc_r(7'h20, 5'd4, 5'd3, 3'd5, 5'd10), 10,
              alu_ref(3'd5, 1'b1, model_x[3], model_x[4]));
    for (int f = 0; f < 8; f++) begin
      im = 12'(lfsr_bits(12));
      if (f == 1 || f == 5) begin
        im[11:5] = 7'd0;
      end
      run_write(enc_i(im, 5'd5, 3'(f), 5'd11, op_imm), 11,
                alu_ref(3'(f), 1'b0, model_x[5], sext12(im)));
    end
    im = {7'h20, 5'(lfsr_bits(5))};
    run_write(enc_i(im, 5'd6, 3'd5, 5'd11, op_imm), 11,
              alu_ref(3'd5, 1'b1, model_x[6], sext12(im)));
  endtask

  task automatic test_hazard();
    int acc1;
    logic [31:0] first;
    send_inst(enc_i(12'd5, 5'd1, 3'd0, 5'd12, op_imm));
    acc1 = last_acc;
    first = model_x[1] + 32'd5;
    send_inst(enc_i(12'd1, 5'd12, 3'd0, 5'd13, op_imm));
    if (last_waits != 2) begin
      $display("dependent instruction waited %0d cycles instead of 2", last_waits);
      errors++;
    end
    expect_wb(12, first, acc1 + 2);
    model_x[12] = first;
    expect_wb(13, first + 32'd1, last_acc + 2);
    model_x[13] = first + 32'd1;
    send_inst(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd14));
    acc1 = last_acc;
    send_inst(enc_r(7'd0, 5'd2, 5'd1, 3'd4, 5'd15));
    if (last_acc != acc1 + 1) begin
      $display("independent instructions were not accepted on consecutive edges");
      errors++;
    end
    expect_wb(14, model_x[1] + model_x[2], acc1 + 2);
    expect_wb(15, model_x[1] ^ model_x[2], acc1 + 3);
    model_x[14] = model_x[1] + model_x[2];
    model_x[15] = model_x[1] ^ model_x[2];
  endtask

  task automatic test_control();
    logic [31:0] t;
    logic [12:0] off;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  conds [6];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    t = lfsr_bits(20) << 12;
    run_write({t[31:12], 5'd16, op_auipc}, 16, pc_now + t);
    send_inst(enc_j(21'h0_0120, 5'd17));
    expect_wb(17, last_pc + 32'd4, last_acc + 2);
    model_x[17] = last_pc + 32'd4;
    expect_redirect(last_pc + 32'h120, last_acc + 2);
    send_inst(enc_i(12'h235, 5'd1, 3'd0, 5'd18, op_jalr));
    expect_wb(18, last_pc + 32'd4, last_acc + 2);
    model_x[18] = last_pc + 32'd4;
    expect_redirect((model_x[1] + 32'h235) & ~32'd1, last_acc + 2);
    for (int c = 0; c < 6; c++) begin
      // two different operands in both orders, and equal operands
      for (int pick = 0; pick < 3; pick++) begin
        off = {11'(lfsr_bits(11)), 2'b00};
        rs1 = (pick == 2) ? 5'd4 : 5'd3;
        rs2 = (pick == 0) ? 5'd4 : 5'd3;
        send_inst(enc_b(off, rs2, rs1, conds[c]));
        t = last_pc + {{19{off[12]}}, off};
        // a follower right behind the branch
        send_inst(enc_i(12'(c + 1), 5'd0, 3'd0, 5'd20, op_imm));
        if (branch_ref(conds[c], model_x[rs1], model_x[rs2])) begin
          expect_redirect(t, last_acc + 1);
        end else begin
          expect_wb(20, 32'(c + 1), last_acc + 2);
          model_x[20] = 32'(c + 1);
        end
        expect_quiet("a branch");
      end
    end
  endtask

  task automatic test_csr();
    logic [31:0] old;
    logic [31:0] ecall_pc;
    run_write(enc_i(csr_mtvec, 5'd0, 3'd2, 5'd21, op_system), 21, m_mtvec);
    old = m_mtvec;
    run_write(enc_i(csr_mtvec, 5'd3, 3'd1, 5'd22, op_system), 22, old);
    m_mtvec = model_x[3];
    old = m_mstatus;
    run_write(enc_i(csr_mstatus, 5'd4, 3'd2, 5'd22, op_system), 22, old);
    m_mstatus = old | model_x[4];
    old = m_mstatus;
    run_write(enc_i(csr_mstatus, 5'd5, 3'd3, 5'd22, op_system), 22, old);
    m_mstatus = old & ~model_x[5];
    run_write(enc_i(csr_mstatus, 5'd0, 3'd2, 5'd22, op_system), 22, m_mstatus);
    old = m_mcause;
    run_write(enc_i(csr_mcause, 5'd6, 3'd1, 5'd22, op_system), 22, old);
    m_mcause = model_x[6];
    run_write(enc_i(csr_mcause, 5'd1, 3'd3, 5'd22, op_system), 22, m_mcause);
    m_mcause = m_mcause & ~model_x[1];
    run_write(enc_i(csr_mcause, 5'd0, 3'd2, 5'd22, op_system), 22, m_mcause);
    run_write(enc_i(csr_mtvec, 5'd0, 3'd2, 5'd22, op_system), 22, m_mtvec);
    send_inst(32'h0000_0073);
    ecall_pc = last_pc;
    expect_redirect(m_mtvec, last_acc + 2);
    m_mepc = ecall_pc;
    m_mcause = cause_ecall_m;
    run_write(enc_i(csr_mepc, 5'd0, 3'd2, 5'd23, op_system), 23, ecall_pc);
    run_write(enc_i(csr_mcause, 5'd0, 3'd2, 5'd24, op_system), 24, 32'd11);
    send_inst(32'h3020_0073);
    expect_redirect(m_mepc, last_acc + 2);
    expect_quiet("the trap sequence");
  endtask

  task automatic test_stall_and_side();
    int acc1;
    send_inst(enc_r(7'd0, 5'd2, 5'd1, 3'd6, 5'd25));
    acc1 = last_acc;
    send_inst(enc_r(7'd0, 5'd2, 5'd1, 3'd7, 5'd26));
    stall = 1'b1;
    repeat (3) @(negedge clock);
    stall = 1'b0;
    expect_wb(25, model_x[1] | model_x[2], acc1 + 5);
    expect_wb(26, model_x[1] & model_x[2], acc1 + 6);
    model_x[25] = model_x[1] | model_x[2];
    model_x[26] = model_x[1] & model_x[2];
    send_inst(enc_i(12'd0, 5'd0, 3'd1, 5'd0, op_misc_mem));
    acc1 = last_acc;
    expect_quiet("FENCE.I");
    if (ccq_edge.size() != 1) begin
      $display("FENCE.I gave %0d clear_cache pulses instead of 1", ccq_edge.size());
      errors++;
    end else if (ccq_edge[0] != acc1 + 2) begin
      $display("clear_cache came at edge %0d instead of %0d", ccq_edge[0], acc1 + 2);
      errors++;
    end
    ccq_edge.delete();
    send_inst(enc_i(12'h010, 5'd1, 3'd2, 5'd27, op_load));
    send_inst({7'd0, 5'd2, 5'd1, 3'd2, 5'd8, op_store});
    send_inst(enc_i(12'h003, 5'd1, 3'd0, 5'd0, op_imm));
    expect_quiet("loads, stores and writes to x0");
  endtask

  initial begin
    errors = 0;
    edge_count = 0;
    lfsr = 32'haec6b40e;
    pc_now = 32'h0000_1000;
    reset = 1'b1;
    inst = 32'd0;
    inst_pc = 32'd0;
    inst_valid = 1'b0;
    stall = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_x[i] = 32'd0;
    end
    m_mstatus = 32'd0;
    m_mtvec = 32'h0000_0100;
    m_mepc = 32'd0;
    m_mcause = 32'd0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_arith();
    test_hazard();
    test_control();
    test_csr();
    test_stall_and_side();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_csr_file.sv
rv_exec_core.sv
tb_rv_exec_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_exec_core -f project.f
./obj_dir/Vtb_rv_exec_core > sim.log 2>&1 || true
cat sim.log
grep -q "PASS: all tests" sim.log
